// ==== rtl/nlc_pkg.sv ====
`default_nettype none

package nlc_pkg;

  // Engine geometry
  localparam int NUM_CH       = 16;
  localparam int ORDER        = 5;
  localparam int FRAC_BITS    = 12;

  // Two normalization steps, then one multiply/add pair per coefficient below coeff[5]
  localparam int STEPS_PER_CH = 12;

  // Channel index
  typedef logic [3:0] ch_t;

  // Raw ADC sample and corrected output
  typedef logic signed [15:0] adc_t;

  // Fixed-point work word with FRAC_BITS fraction bits
  typedef logic signed [31:0] word_t;

  // One channel's calibration set
  typedef struct packed {
    word_t              neg_mean;
    word_t              recip_stdev;
    word_t [ORDER:0]    coeff;
  } cal_t;

  // Datapath operation for the current cycle
  typedef enum logic [3:0] {
    ST_ADD_MEAN,
    ST_MUL_STD,
    ST_MUL,
    ST_ADD
  } step_t;

  // One corrected output tagged with its channel
  typedef struct packed {
    ch_t  ch;
    adc_t value;
  } result_t;

  // Sample into the work format
  function automatic word_t to_word(input adc_t s);
    word_t w;
    w = word_t'(s);
    return w <<< FRAC_BITS;
  endfunction

  // Full-width product rescaled back to FRAC_BITS
  function automatic word_t fix_mul(input word_t a, input word_t b);
    logic signed [63:0] p;
    p = 64'(a) * 64'(b);
    return word_t'(p >>> FRAC_BITS);
  endfunction

  // Work word back to sample width as its integer part
  function automatic adc_t to_adc(input word_t w);
    word_t shifted;
    shifted = w >>> FRAC_BITS;
    return adc_t'(shifted);
  endfunction

endpackage

`default_nettype wire

// ==== rtl/chan_bank.sv ====
`default_nettype none

// One register per channel
// Used for the calibration sets and for the raw samples
module chan_bank
  import nlc_pkg::*;
#(
  parameter type payload_t = adc_t
) (
  input  logic     clk,
  input  logic     rst,

  // Write side
  input  logic     we,
  input  ch_t      wr_ch,
  input  payload_t wr_data,

  // Read side, combinational
  input  ch_t      rd_ch,
  output payload_t rd_data
);

  payload_t regs [NUM_CH];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_CH; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[wr_ch] <= wr_data;
    end
  end

  assign rd_data = regs[rd_ch];

endmodule

`default_nettype wire

// ==== rtl/nlc_sequencer.sv ====
`default_nettype none

// Walks all channels in order with STEPS_PER_CH cycles each
module nlc_sequencer
  import nlc_pkg::*;
(
  input  logic       clk,
  input  logic       rst,

  input  logic       start,
  output logic       busy,

  // To banks and datapath
  output ch_t        rd_ch,
  output step_t      step,
  output logic [2:0] coeff_idx,
  output logic       last,

  output logic       done
);

  ch_t        ch_cnt;
  logic [3:0] step_cnt;

  // Final step of the current channel
  assign last = busy && (step_cnt == 4'(STEPS_PER_CH - 1));

  assign rd_ch = ch_cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy     <= 1'b0;
      done     <= 1'b0;
      ch_cnt   <= '0;
      step_cnt <= '0;
    end else begin
      done <= 1'b0;
      if (!busy) begin
        // Start is ignored while a pass runs
        if (start) begin
          busy     <= 1'b1;
          ch_cnt   <= '0;
          step_cnt <= '0;
        end
      end else if (last) begin
        step_cnt <= '0;
        ch_cnt   <= ch_cnt + 1'b1;
        if (ch_cnt == ch_t'(NUM_CH - 1)) begin
          // Lines up with the final out_valid
          busy <= 1'b0;
          done <= 1'b1;
        end
      end else begin
        step_cnt <= step_cnt + 1'b1;
      end
    end
  end

  // Step kind from the count
  // 0 and 1 normalize, then even counts multiply and odd counts add
  always_comb begin
    if (step_cnt == 4'd0) begin
      step = ST_ADD_MEAN;
    end else if (step_cnt == 4'd1) begin
      step = ST_MUL_STD;
    end else if (!step_cnt[0]) begin
      step = ST_MUL;
    end else begin
      step = ST_ADD;
    end
  end

  // Pair for coeff[k] sits at counts 10-2k and 11-2k
  // The MUL of a pair sees k+1 and the ADD sees k
  always_comb begin
    if (step_cnt < 4'd2) begin
      coeff_idx = '0;
    end else begin
      coeff_idx = 3'((4'(STEPS_PER_CH) - step_cnt) >> 1);
    end
  end

endmodule

`default_nettype wire

// ==== rtl/nlc_datapath.sv ====
`default_nettype none

// Normalization and Horner evaluation, one operation per cycle
module nlc_datapath
  import nlc_pkg::*;
(
  input  logic       clk,
  input  logic       rst,

  // From the sequencer
  input  step_t      step,
  input  logic [2:0] coeff_idx,
  input  logic       last,
  input  ch_t        rd_ch,

  // From the banks
  input  cal_t       cal,
  input  adc_t       sample,

  output logic       out_valid,
  output result_t    out
);

  word_t acc;
  word_t norm;
  word_t acc_next;
  word_t norm_next;
  word_t mul_op;
  word_t add_op;

  // First pair starts Horner from the top coefficient
  assign mul_op = (coeff_idx == 3'(ORDER)) ? cal.coeff[ORDER] : acc;

  assign add_op = cal.coeff[coeff_idx];

  always_comb begin
    acc_next  = acc;
    norm_next = norm;
    case (step)
      ST_ADD_MEAN: begin
        acc_next = to_word(sample) + cal.neg_mean;
      end
      ST_MUL_STD: begin
        norm_next = fix_mul(acc, cal.recip_stdev);
      end
      ST_MUL: begin
        acc_next = fix_mul(mul_op, norm);
      end
      ST_ADD: begin
        acc_next = acc + add_op;
      end
      default: begin
        acc_next = acc;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    acc  <= acc_next;
    norm <= norm_next;
  end

  // Result taken straight from the final add
  always_ff @(posedge clk) begin
    if (last) begin
      out.ch    <= rd_ch;
      out.value <= to_adc(acc_next);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= last;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/nlc_top.sv ====
`default_nettype none

module nlc_top
  import nlc_pkg::*;
(
  input  logic    clk,
  input  logic    rst,

  // Calibration write
  input  logic    cal_we,
  input  ch_t     cal_ch,
  input  cal_t    cal_data,

  // Sample write
  input  logic    sample_we,
  input  ch_t     sample_ch,
  input  adc_t    sample,

  input  logic    start,
  output logic    busy,

  output logic    out_valid,
  output result_t out,
  output logic    done
);

  ch_t        rd_ch;
  cal_t       cal_rd;
  adc_t       sample_rd;
  step_t      step;
  logic [2:0] coeff_idx;
  logic       last;

  chan_bank #(
    .payload_t (cal_t)
  ) u_cal_bank (
    .clk     (clk),
    .rst     (rst),
    .we      (cal_we),
    .wr_ch   (cal_ch),
    .wr_data (cal_data),
    .rd_ch   (rd_ch),
    .rd_data (cal_rd)
  );

  chan_bank #(
    .payload_t (adc_t)
  ) u_sample_bank (
    .clk     (clk),
    .rst     (rst),
    .we      (sample_we),
    .wr_ch   (sample_ch),
    .wr_data (sample),
    .rd_ch   (rd_ch),
    .rd_data (sample_rd)
  );

  nlc_sequencer u_seq (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .busy      (busy),
    .rd_ch     (rd_ch),
    .step      (step),
    .coeff_idx (coeff_idx),
    .last      (last),
    .done      (done)
  );

  nlc_datapath u_dp (
    .clk       (clk),
    .rst       (rst),
    .step      (step),
    .coeff_idx (coeff_idx),
    .last      (last),
    .rd_ch     (rd_ch),
    .cal       (cal_rd),
    .sample    (sample_rd),
    .out_valid (out_valid),
    .out       (out)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_clock.sv ====
`default_nettype none

// 20 ns clock, reset held for the first 3 rising edges
module tb_clock (
  output logic clk,
  output logic rst
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

`default_nettype wire

// ==== testbench/tb_nlc.sv ====
`default_nettype none

module tb_nlc
  import nlc_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int DONE_TIMEOUT = 400;
  localparam int RESET_TIMEOUT = 20;
  localparam int SETTLE_CYCLES = 16;
  localparam int unsigned SEED = 32'h3adf_f041;

  logic    clk;
  logic    rst;
  logic    cal_we;
  ch_t     cal_ch;
  cal_t    cal_data;
  logic    sample_we;
  ch_t     sample_ch;
  adc_t    sample;
  logic    start;
  logic    busy;
  logic    out_valid;
  result_t out;
  logic    done;

  // Shadow of what the banks hold
  cal_t    cal_model [NUM_CH];
  adc_t    sample_model [NUM_CH];
  result_t captured [NUM_CH];
  result_t previous [NUM_CH];

  string cur_test = "reset";
  int    test_errors = 0;
  int    total_errors = 0;
  int    tests_run = 0;
  int    tests_failed = 0;
  int    total_results = 0;
  int    total_dones = 0;
  int    pass_base = 0;

  tb_clock u_clock (
    .clk (clk),
    .rst (rst)
  );

  nlc_top u_nlc_top (
    .clk       (clk),
    .rst       (rst),
    .cal_we    (cal_we),
    .cal_ch    (cal_ch),
    .cal_data  (cal_data),
    .sample_we (sample_we),
    .sample_ch (sample_ch),
    .sample    (sample),
    .start     (start),
    .busy      (busy),
    .out_valid (out_valid),
    .out       (out),
    .done      (done)
  );

  // Q20.12 product with the low 32 bits kept
  function automatic word_t scale_product(input word_t a, input word_t b);
    logic signed [63:0] wide_a;
    logic signed [63:0] wide_b;
    logic signed [63:0] prod;
    wide_a = a;
    wide_b = b;
    prod = wide_a * wide_b;
    prod = prod >>> FRAC_BITS;
    return prod[31:0];
  endfunction

  // Normalize, then Horner from coeff[5] down to coeff[0]
  function automatic adc_t ref_channel(input cal_t cal, input adc_t smp);
    word_t acc;
    word_t norm;
    acc = word_t'(smp);
    acc = acc <<< FRAC_BITS;
    acc = acc + cal.neg_mean;
    norm = scale_product(acc, cal.recip_stdev);
    acc = cal.coeff[ORDER];
    for (int k = ORDER - 1; k >= 0; k--) begin
      acc = scale_product(acc, norm);
      acc = acc + cal.coeff[k];
    end
    acc = acc >>> FRAC_BITS;
    return acc[15:0];
  endfunction

  function automatic cal_t random_cal();
    cal_t c;
    c.neg_mean = word_t'($signed($urandom)) >>> 4;
    c.recip_stdev = word_t'($urandom_range(1, 64));
    for (int k = 0; k <= ORDER; k++) begin
      c.coeff[k] = word_t'($signed($urandom)) >>> 16;
    end
    return c;
  endfunction

  task automatic note_error();
    test_errors++;
    total_errors++;
  endtask

  task automatic check_result(input string what, input result_t expected, input result_t actual);
    if (actual !== expected) begin
      $display("Error in %s, %s: expected ch %0d value %0d, actual ch %0d value %0d",
               cur_test, what, expected.ch, expected.value, actual.ch, actual.value);
      note_error();
    end
  endtask

  task automatic check_count(input string what, input int expected, input int actual);
    if (actual != expected) begin
      $display("Error in %s, %s: expected %0d, actual %0d", cur_test, what, expected, actual);
      note_error();
    end
  endtask

  task automatic check_flag(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("Error in %s, %s: expected %b, actual %b", cur_test, what, expected, actual);
      note_error();
    end
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errors == 0) begin
      $display("Test %s: passed", cur_test);
    end else begin
      tests_failed++;
      $display("Test %s: failed with %0d errors", cur_test, test_errors);
    end
  endtask

  task automatic write_cal(input ch_t ch, input cal_t c);
    @(negedge clk);
    cal_we = 1'b1;
    cal_ch = ch;
    cal_data = c;
    @(negedge clk);
    cal_we = 1'b0;
    cal_model[ch] = c;
  endtask

  task automatic write_sample(input ch_t ch, input adc_t s);
    @(negedge clk);
    sample_we = 1'b1;
    sample_ch = ch;
    sample = s;
    @(negedge clk);
    sample_we = 1'b0;
    sample_model[ch] = s;
  endtask

  // One pass with a repeated start at cycle extra_start when it is nonzero
  task automatic run_pass(input int extra_start);
    int cycles;
    int results_before;
    int dones_before;
    bit seen;
    @(negedge clk);
    pass_base = total_results;
    results_before = total_results;
    dones_before = total_dones;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    cycles = 0;
    seen = 1'b0;
    while (!seen && cycles < DONE_TIMEOUT) begin
      @(negedge clk);
      cycles++;
      start = 1'b0;
      if (cycles == extra_start) begin
        check_flag("busy at repeated start", 1'b1, busy);
        start = 1'b1;
      end
      if (done) begin
        seen = 1'b1;
      end
    end
    start = 1'b0;
    if (!seen) begin
      $display("Timeout in %s: done did not arrive within %0d cycles", cur_test, DONE_TIMEOUT);
      note_error();
    end
    // Room for late or stray results
    repeat (SETTLE_CYCLES) @(negedge clk);
    check_count("results in pass", NUM_CH, total_results - results_before);
    check_count("done pulses in pass", 1, total_dones - dones_before);
    check_flag("busy after pass", 1'b0, busy);
  endtask

  // Compare every result as it appears
  always @(negedge clk) begin
    result_t expected;
    int idx;
    if (!rst && out_valid) begin
      idx = total_results - pass_base;
      expected.ch = ch_t'(idx);
      expected.value = ref_channel(cal_model[expected.ch], sample_model[expected.ch]);
      check_result("result", expected, out);
      captured[expected.ch] = out;
      total_results++;
    end
    if (!rst && done) begin
      total_dones++;
      check_flag("done with channel 15 result", 1'b1,
                 out_valid && (out.ch == ch_t'(NUM_CH - 1)));
      check_flag("busy at done", 1'b0, busy);
    end
  end

  initial begin
    int wait_cycles;
    cal_t c;
    result_t exp_res;
    word_t w;
    void'($urandom(SEED));
    cal_we = 1'b0;
    cal_ch = '0;
    cal_data = '0;
    sample_we = 1'b0;
    sample_ch = '0;
    sample = '0;
    start = 1'b0;
    for (int ch = 0; ch < NUM_CH; ch++) begin
      cal_model[ch] = '0;
      sample_model[ch] = '0;
    end

    wait_cycles = 0;
    while (rst !== 1'b0 && wait_cycles < RESET_TIMEOUT) begin
      @(negedge clk);
      wait_cycles++;
    end
    if (rst !== 1'b0) begin
      $display("Reset was never released");
      note_error();
    end

    // Banks are empty after reset, so every result is zero
    begin_test("idle_then_pass");
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      check_flag("busy while idle", 1'b0, busy);
      check_flag("out_valid while idle", 1'b0, out_valid);
      check_flag("done while idle", 1'b0, done);
    end
    run_pass(0);
    end_test();

    begin_test("coeff0_only");
    for (int ch = 0; ch < NUM_CH; ch++) begin
      c = '0;
      c.recip_stdev = word_t'(1 << FRAC_BITS);
      c.coeff[0] = word_t'($signed($urandom)) >>> 4;
      write_cal(ch_t'(ch), c);
      write_sample(ch_t'(ch), adc_t'($urandom));
    end
    run_pass(0);
    for (int ch = 0; ch < NUM_CH; ch++) begin
      w = cal_model[ch].coeff[0];
      w = w >>> FRAC_BITS;
      exp_res.ch = ch_t'(ch);
      exp_res.value = w[15:0];
      check_result("coeff[0] passthrough", exp_res, captured[ch]);
    end
    end_test();

    begin_test("random_all_channels");
    for (int ch = 0; ch < NUM_CH; ch++) begin
      write_cal(ch_t'(ch), random_cal());
      write_sample(ch_t'(ch), adc_t'($urandom));
    end
    run_pass(0);
    end_test();

    begin_test("start_while_busy");
    run_pass(60);
    end_test();

    begin_test("rewrite_one_channel");
    previous = captured;
    write_cal(ch_t'(9), random_cal());
    run_pass(0);
    for (int ch = 0; ch < NUM_CH; ch++) begin
      if (ch != 9) begin
        check_result("unchanged channel", previous[ch], captured[ch]);
      end
    end
    end_test();

    $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, total_errors);
    if (total_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
rtl/nlc_pkg.sv
rtl/chan_bank.sv
rtl/nlc_sequencer.sv
rtl/nlc_datapath.sv
rtl/nlc_top.sv
testbench/tb_clock.sv
testbench/tb_nlc.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_nlc
RTL_TOP    := nlc_top
FILELIST   := sources.f
OBJ_DIR    := obj_dir
LOG        := sim.log

COMMON     := --timing --timescale 1ns/1ps
LINT_FLAGS := --lint-only -Wall $(COMMON)
SIM_FLAGS  := --binary $(COMMON)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "NO ERRORS" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
